// File: logic/isa_pkg.sv
// RV64I encodings and the instruction-word union; referenced by scoped name from all RTL
package isa_pkg;

  localparam int xlen = 64;

  typedef logic [4:0]      gpr_addr_t;
  typedef logic [xlen-1:0] xword_t;

  typedef enum logic [6:0] {
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    OP_IMM   = 7'b0010011,
    OP_IMM32 = 7'b0011011,
    OP       = 7'b0110011,
    OP32     = 7'b0111011,
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    BRANCH   = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    PASS_B // lui
  } alu_op_e;

  // branch conditions keep their funct3, jumps use the free codes
  typedef enum logic [2:0] {
    BEQ      = 3'b000,
    BNE      = 3'b001,
    JUMP     = 3'b010,
    JUMP_REG = 3'b011, // jalr
    BLT      = 3'b100,
    BGE      = 3'b101,
    BLTU     = 3'b110,
    BGEU     = 3'b111
  } br_func_e;

  typedef struct packed {
    logic [6:0] funct7;
    gpr_addr_t  rs2;
    gpr_addr_t  rs1;
    logic [2:0] funct3;
    gpr_addr_t  rd;
    logic [6:0] opcode;
  } inst_reg_t;

  typedef struct packed {
    logic [11:0] imm_hi; // inst[31:20]
    gpr_addr_t   rs1;
    logic [2:0]  funct3;
    logic [4:0]  imm_lo; // inst[11:7]
    logic [6:0]  opcode;
  } inst_imm_t;

  typedef union packed {
    inst_reg_t r;
    inst_imm_t im;
  } inst_u;

endpackage

// File: logic/pipe_pkg.sv
// inter-stage buses of the pipeline around decode; referenced by scoped name
package pipe_pkg;

  typedef struct packed {
    isa_pkg::inst_u  inst;
    isa_pkg::xword_t pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic              src1_sel;    // 1: pc
    logic              src2_sel;    // 1: immediate
    logic              word_sel;    // 32-bit op, result sign-extended
    isa_pkg::alu_op_e  alu_op;
    logic              gpr_wen;
    logic              mem_ren;
    logic              mem_wen;
    logic [2:0]        mem_op;      // funct3 of load/store
    logic              load_sel;
    logic              invalid_sel;
  } ds_ctrl_t;

  typedef struct packed {
    ds_ctrl_t           ctrl;
    isa_pkg::xword_t    rs1_data;
    isa_pkg::xword_t    rs2_data;
    isa_pkg::xword_t    imm;
    isa_pkg::xword_t    pc;
    isa_pkg::gpr_addr_t rd;
  } ds_to_es_t;

  typedef struct packed {
    logic               wen;
    isa_pkg::gpr_addr_t addr;
    isa_pkg::xword_t    data;
  } rf_write_t;

  // rd of 0 means nothing to forward
  typedef struct packed {
    isa_pkg::gpr_addr_t rd;
    isa_pkg::xword_t    result;
  } bypass_t;

  typedef struct packed {
    logic            stall;
    logic            taken;
    isa_pkg::xword_t target;
  } br_bus_t;

endpackage

// File: logic/id_stage_ctrl.sv
// decode stage valid/allowin handshake, instruction latch and load-use stall
`timescale 1ns/100ps

module id_stage_ctrl (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_fs_to_ds_valid,
  input  pipe_pkg::fs_to_ds_t i_fs_to_ds_bus,
  input  logic                i_es_allowin,
  input  logic                i_es_load_sel,
  input  isa_pkg::gpr_addr_t  i_es_rd,
  input  isa_pkg::gpr_addr_t  i_rs1,
  input  isa_pkg::gpr_addr_t  i_rs2,
  output logic                o_ds_allowin,
  output logic                o_ds_to_es_valid,
  output logic                o_ds_valid,
  output logic                o_load_stall,
  output pipe_pkg::fs_to_ds_t o_fs_to_ds_r
);

  logic ds_valid;
  logic ds_ready_go;

  // load in execute has no result yet, wait until it reaches memory
  assign o_load_stall = i_es_load_sel && (i_es_rd != '0) &&
                        ((i_es_rd == i_rs1) || (i_es_rd == i_rs2));

  assign ds_ready_go      = !o_load_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  assign o_ds_valid       = ds_valid;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid; // drops to empty when fetch has nothing
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_fs_to_ds_r <= '0;
    end else if (i_fs_to_ds_valid && o_ds_allowin) begin
      o_fs_to_ds_r <= i_fs_to_ds_bus;
    end
  end

endmodule

// File: logic/inst_decoder.sv
// RV64I integer decoder; register indices, immediates and execute control from one word
`timescale 1ns/100ps

module inst_decoder (
  input  isa_pkg::inst_u     i_inst,
  output isa_pkg::gpr_addr_t o_rs1,
  output isa_pkg::gpr_addr_t o_rs2,
  output isa_pkg::gpr_addr_t o_rd,
  output isa_pkg::xword_t    o_imm,
  output pipe_pkg::ds_ctrl_t o_ctrl,
  output logic               o_bren,
  output isa_pkg::br_func_e  o_brfunc
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic             alt_ok;  // funct3 that allow the 0100000 variant
  logic             f7_ok;
  logic             w_f3_ok; // funct3 present in the 32-bit ops
  logic             sh64_ok;
  logic             inst_ok;
  isa_pkg::alu_op_e f3_op;
  isa_pkg::xword_t  imm_i;
  isa_pkg::xword_t  imm_s;
  isa_pkg::xword_t  imm_b;
  isa_pkg::xword_t  imm_u;
  isa_pkg::xword_t  imm_j;

  assign opcode = i_inst.r.opcode;
  assign funct3 = i_inst.r.funct3;
  assign funct7 = i_inst.r.funct7;
  assign o_rs1  = i_inst.r.rs1;
  assign o_rs2  = i_inst.r.rs2;
  assign o_rd   = i_inst.r.rd;

  assign imm_i = {{52{i_inst.im.imm_hi[11]}}, i_inst.im.imm_hi};
  assign imm_s = {{52{i_inst.im.imm_hi[11]}}, i_inst.im.imm_hi[11:5], i_inst.im.imm_lo};
  assign imm_b = {{52{i_inst.im.imm_hi[11]}}, i_inst.im.imm_lo[0], i_inst.im.imm_hi[10:5],
                  i_inst.im.imm_lo[4:1], 1'b0};
  assign imm_u = {{32{i_inst.im.imm_hi[11]}}, i_inst.im.imm_hi, i_inst.im.rs1,
                  i_inst.im.funct3, 12'b0};
  assign imm_j = {{44{i_inst.im.imm_hi[11]}}, i_inst.im.rs1, i_inst.im.funct3,
                  i_inst.im.imm_hi[0], i_inst.im.imm_hi[10:1], 1'b0};

  assign alt_ok  = (funct3 == 3'b000) || (funct3 == 3'b101);
  assign f7_ok   = (funct7 == 7'b0000000) || ((funct7 == 7'b0100000) && alt_ok);
  assign w_f3_ok = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101);
  // 6-bit shamt, so only funct7[6:1] is fixed
  assign sh64_ok = (funct7[6:1] == 6'b0) || ((funct7[6:1] == 6'b010000) && funct3[2]);

  always_comb begin
    case (funct3)
      3'b000:  f3_op = (funct7[5] && opcode[5]) ? isa_pkg::SUB : isa_pkg::ADD; // no subi
      3'b001:  f3_op = isa_pkg::SLL;
      3'b010:  f3_op = isa_pkg::SLT;
      3'b011:  f3_op = isa_pkg::SLTU;
      3'b100:  f3_op = isa_pkg::XOR;
      3'b101:  f3_op = funct7[5] ? isa_pkg::SRA : isa_pkg::SRL;
      3'b110:  f3_op = isa_pkg::OR;
      default: f3_op = isa_pkg::AND;
    endcase
  end

  always_comb begin
    o_ctrl        = '0;
    o_ctrl.alu_op = isa_pkg::ADD;
    o_imm         = '0;
    o_bren        = 1'b0;
    o_brfunc      = isa_pkg::BEQ;
    inst_ok       = 1'b1;
    case (opcode)
      isa_pkg::LOAD: begin
        o_imm           = imm_i;
        o_ctrl.src2_sel = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.mem_ren  = 1'b1;
        o_ctrl.mem_op   = funct3;
        o_ctrl.load_sel = 1'b1;
        inst_ok         = (funct3 != 3'b111);
      end
      isa_pkg::STORE: begin
        o_imm           = imm_s;
        o_ctrl.src2_sel = 1'b1;
        o_ctrl.mem_wen  = 1'b1;
        o_ctrl.mem_op   = funct3;
        inst_ok         = !funct3[2];
      end
      isa_pkg::OP_IMM, isa_pkg::OP_IMM32: begin
        o_imm           = imm_i;
        o_ctrl.src2_sel = 1'b1;
        o_ctrl.word_sel = opcode[3];
        o_ctrl.alu_op   = f3_op;
        o_ctrl.gpr_wen  = 1'b1;
        if (opcode[3]) begin
          inst_ok = w_f3_ok && ((funct3 == 3'b000) || f7_ok);
        end else begin
          inst_ok = (funct3[1:0] != 2'b01) || sh64_ok;
        end
      end
      isa_pkg::OP, isa_pkg::OP32: begin
        o_ctrl.word_sel = opcode[3];
        o_ctrl.alu_op   = f3_op;
        o_ctrl.gpr_wen  = 1'b1;
        inst_ok         = f7_ok && (!opcode[3] || w_f3_ok);
      end
      isa_pkg::LUI: begin
        o_imm           = imm_u;
        o_ctrl.src2_sel = 1'b1;
        o_ctrl.alu_op   = isa_pkg::PASS_B;
        o_ctrl.gpr_wen  = 1'b1;
      end
      isa_pkg::AUIPC: begin
        o_imm           = imm_u;
        o_ctrl.src1_sel = 1'b1;
        o_ctrl.src2_sel = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
      end
      isa_pkg::JAL, isa_pkg::JALR: begin
        o_imm           = (opcode == isa_pkg::JAL) ? imm_j : imm_i;
        o_ctrl.src1_sel = 1'b1; // link value, execute adds 4 to pc
        o_ctrl.gpr_wen  = 1'b1;
        o_bren          = 1'b1;
        o_brfunc        = (opcode == isa_pkg::JAL) ? isa_pkg::JUMP : isa_pkg::JUMP_REG;
        inst_ok         = (opcode == isa_pkg::JAL) || (funct3 == 3'b000);
      end
      isa_pkg::BRANCH: begin
        o_imm    = imm_b;
        o_bren   = 1'b1;
        o_brfunc = isa_pkg::br_func_e'(funct3);
        inst_ok  = (funct3[2:1] != 2'b01);
      end
      default: inst_ok = 1'b0;
    endcase
    // flagged and passed on, but harmless
    if (!inst_ok) begin
      o_ctrl.gpr_wen  = 1'b0;
      o_ctrl.mem_ren  = 1'b0;
      o_ctrl.mem_wen  = 1'b0;
      o_ctrl.load_sel = 1'b0;
      o_bren          = 1'b0;
    end
    o_ctrl.invalid_sel = !inst_ok;
  end

endmodule

// File: logic/gpr_file.sv
// integer register file, 32 x 64, two combinational reads and one write from writeback
`timescale 1ns/100ps

module gpr_file (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  isa_pkg::gpr_addr_t  i_raddr1,
  input  isa_pkg::gpr_addr_t  i_raddr2,
  input  pipe_pkg::rf_write_t i_wr,
  output isa_pkg::xword_t     o_rdata1,
  output isa_pkg::xword_t     o_rdata2
);

  isa_pkg::xword_t regs [0:31];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wr.wen && (i_wr.addr != '0)) begin
      regs[i_wr.addr] <= i_wr.data; // x0 never written, stays 0
    end
  end

  // same-cycle write is covered by the writeback bypass
  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

endmodule

// File: logic/operand_bypass.sv
// source operand forwarding; execute over memory over writeback over register file
`timescale 1ns/100ps

module operand_bypass (
  input  isa_pkg::gpr_addr_t i_rs1,
  input  isa_pkg::gpr_addr_t i_rs2,
  input  isa_pkg::xword_t    i_rf_rdata1,
  input  isa_pkg::xword_t    i_rf_rdata2,
  input  pipe_pkg::bypass_t  i_es,
  input  pipe_pkg::bypass_t  i_ms,
  input  pipe_pkg::bypass_t  i_ws,
  output isa_pkg::xword_t    o_rs1_data,
  output isa_pkg::xword_t    o_rs2_data
);

  function automatic isa_pkg::xword_t pick(input isa_pkg::gpr_addr_t rs,
                                           input isa_pkg::xword_t rf_data,
                                           input pipe_pkg::bypass_t es,
                                           input pipe_pkg::bypass_t ms,
                                           input pipe_pkg::bypass_t ws);
    isa_pkg::xword_t data;
    data = rf_data;
    // lowest priority first, later checks override
    if ((ws.rd != '0) && (ws.rd == rs)) data = ws.result;
    if ((ms.rd != '0) && (ms.rd == rs)) data = ms.result;
    if ((es.rd != '0) && (es.rd == rs)) data = es.result;
    return data;
  endfunction

  assign o_rs1_data = pick(i_rs1, i_rf_rdata1, i_es, i_ms, i_ws);
  assign o_rs2_data = pick(i_rs2, i_rf_rdata2, i_es, i_ms, i_ws);

endmodule

// File: logic/branch_unit.sv
// branch compare and jump target; drives the redirect bus back to fetch
`timescale 1ns/100ps

module branch_unit (
  input  logic              i_valid,
  input  logic              i_load_stall,
  input  logic              i_bren,
  input  isa_pkg::br_func_e i_brfunc,
  input  isa_pkg::xword_t   i_rs1_data,
  input  isa_pkg::xword_t   i_rs2_data,
  input  isa_pkg::xword_t   i_pc,
  input  isa_pkg::xword_t   i_imm,
  output pipe_pkg::br_bus_t o_br_bus
);

  logic            eq;
  logic            lt;
  logic            ltu;
  logic            cond;
  isa_pkg::xword_t reg_target;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_brfunc)
      isa_pkg::BEQ:                    cond = eq;
      isa_pkg::BNE:                    cond = !eq;
      isa_pkg::BLT:                    cond = lt;
      isa_pkg::BGE:                    cond = !lt;
      isa_pkg::BLTU:                   cond = ltu;
      isa_pkg::BGEU:                   cond = !ltu;
      isa_pkg::JUMP, isa_pkg::JUMP_REG: cond = 1'b1;
      default:                         cond = 1'b0;
    endcase
  end

  assign reg_target = i_rs1_data + i_imm;

  assign o_br_bus.taken  = i_valid && i_bren && cond;
  assign o_br_bus.stall  = o_br_bus.taken && i_load_stall; // rs data not yet final
  assign o_br_bus.target = (i_brfunc == isa_pkg::JUMP_REG) ? {reg_target[63:1], 1'b0}
                                                           : i_pc + i_imm;

endmodule

// File: logic/id_stage.sv
// decode stage top level; connects control, decoder, register file, forwarding and branch unit
`timescale 1ns/100ps

module id_stage (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_fs_to_ds_valid,
  input  pipe_pkg::fs_to_ds_t i_fs_to_ds_bus,
  input  logic                i_es_allowin,
  input  logic                i_es_load_sel,
  input  pipe_pkg::bypass_t   i_es_bypass,
  input  pipe_pkg::bypass_t   i_ms_bypass,
  input  pipe_pkg::bypass_t   i_ws_bypass,
  input  pipe_pkg::rf_write_t i_ws_to_rf,
  output logic                o_ds_allowin,
  output logic                o_ds_to_es_valid,
  output pipe_pkg::ds_to_es_t o_ds_to_es_bus,
  output pipe_pkg::br_bus_t   o_br_bus
);

  pipe_pkg::fs_to_ds_t fs_to_ds_r;
  logic                ds_valid;
  logic                load_stall;
  isa_pkg::gpr_addr_t  rs1;
  isa_pkg::gpr_addr_t  rs2;
  isa_pkg::gpr_addr_t  rd;
  isa_pkg::xword_t     imm;
  pipe_pkg::ds_ctrl_t  ctrl;
  logic                bren;
  isa_pkg::br_func_e   brfunc;
  isa_pkg::xword_t     rf_rdata1;
  isa_pkg::xword_t     rf_rdata2;
  isa_pkg::xword_t     rs1_data;
  isa_pkg::xword_t     rs2_data;

  assign o_ds_to_es_bus = '{ctrl: ctrl, rs1_data: rs1_data, rs2_data: rs2_data,
                            imm: imm, pc: fs_to_ds_r.pc, rd: rd};

  id_stage_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_to_ds_bus   (i_fs_to_ds_bus),
    .i_es_allowin     (i_es_allowin),
    .i_es_load_sel    (i_es_load_sel),
    .i_es_rd          (i_es_bypass.rd),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_valid       (ds_valid),
    .o_load_stall     (load_stall),
    .o_fs_to_ds_r     (fs_to_ds_r)
  );

  inst_decoder u_decoder (
    .i_inst   (fs_to_ds_r.inst),
    .o_rs1    (rs1),
    .o_rs2    (rs2),
    .o_rd     (rd),
    .o_imm    (imm),
    .o_ctrl   (ctrl),
    .o_bren   (bren),
    .o_brfunc (brfunc)
  );

  gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wr     (i_ws_to_rf),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

  operand_bypass u_bypass (
    .i_rs1       (rs1),
    .i_rs2       (rs2),
    .i_rf_rdata1 (rf_rdata1),
    .i_rf_rdata2 (rf_rdata2),
    .i_es        (i_es_bypass),
    .i_ms        (i_ms_bypass),
    .i_ws        (i_ws_bypass),
    .o_rs1_data  (rs1_data),
    .o_rs2_data  (rs2_data)
  );

  branch_unit u_bru (
    .i_valid      (ds_valid),
    .i_load_stall (load_stall),
    .i_bren       (bren),
    .i_brfunc     (brfunc),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .i_pc         (fs_to_ds_r.pc),
    .i_imm        (imm),
    .o_br_bus     (o_br_bus)
  );

endmodule

// File: testbench/id_stage_asserts.sv
// handshake assertions for the decode stage control, bound into every id_stage_ctrl
`timescale 1ns/100ps

module id_stage_asserts (
  input logic                i_clk,
  input logic                i_rst_n,
  input logic                i_es_load_sel,
  input isa_pkg::gpr_addr_t  i_es_rd,
  input isa_pkg::gpr_addr_t  i_rs1,
  input isa_pkg::gpr_addr_t  i_rs2,
  input logic                o_ds_allowin,
  input logic                o_ds_to_es_valid,
  input logic                o_ds_valid,
  input pipe_pkg::fs_to_ds_t o_fs_to_ds_r
);

  int   fail_count = 0;
  logic load_use;

  // load in execute targets a source of the held instruction
  assign load_use = i_es_load_sel && (i_es_rd != '0) &&
                    ((i_es_rd == i_rs1) || (i_es_rd == i_rs2));

  no_valid_in_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    load_use |-> !o_ds_to_es_valid)
    else begin
      fail_count++;
      $error("valid to execute during a load-use stall");
    end

  // a held instruction must not move
  latch_holds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_ds_valid && !o_ds_allowin) |=> $stable(o_fs_to_ds_r))
    else begin
      fail_count++;
      $error("instruction latch changed while blocked");
    end

  allowin_after_reset: assert property (@(posedge i_clk)
    $rose(i_rst_n) |-> o_ds_allowin)
    else begin
      fail_count++;
      $error("allowin low right after reset");
    end

endmodule

bind id_stage_ctrl id_stage_asserts u_asserts (
  .i_clk            (i_clk),
  .i_rst_n          (i_rst_n),
  .i_es_load_sel    (i_es_load_sel),
  .i_es_rd          (i_es_rd),
  .i_rs1            (i_rs1),
  .i_rs2            (i_rs2),
  .o_ds_allowin     (o_ds_allowin),
  .o_ds_to_es_valid (o_ds_to_es_valid),
  .o_ds_valid       (o_ds_valid),
  .o_fs_to_ds_r     (o_fs_to_ds_r)
);

// File: testbench/tb_id_stage.sv
// testbench for the decode stage; replays golden vectors from a file and checks the DUT outputs
`timescale 1ns/100ps

module tb_id_stage;

  localparam int n_fields = 26;

  logic                i_clk;
  logic                i_rst_n;
  logic                i_fs_to_ds_valid;
  pipe_pkg::fs_to_ds_t i_fs_to_ds_bus;
  logic                i_es_allowin;
  logic                i_es_load_sel;
  pipe_pkg::bypass_t   i_es_bypass;
  pipe_pkg::bypass_t   i_ms_bypass;
  pipe_pkg::bypass_t   i_ws_bypass;
  pipe_pkg::rf_write_t i_ws_to_rf;
  logic                o_ds_allowin;
  logic                o_ds_to_es_valid;
  pipe_pkg::ds_to_es_t o_ds_to_es_bus;
  pipe_pkg::br_bus_t   o_br_bus;

  logic [63:0] fields[$]; // n_fields entries per vector
  int          nvec;
  logic        loaded;

  id_stage i_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    string msg;
    if (actual !== expected) begin
      msg = $sformatf("** Error: %s is %h, expected %h", name, actual, expected);
      report_failure(msg);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          got;
    string       line;
    logic [63:0] v [n_fields];
    fd = $fopen("testbench/id_golden.txt", "r");
    if (fd == 0) begin
      report_failure("could not open the golden vector file testbench/id_golden.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.substr(0, 0) == "#") continue; // skip comments and blank lines
      got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11],
                    v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20], v[21],
                    v[22], v[23], v[24], v[25]);
      if (got != n_fields) begin
        report_failure("a line of the golden vector file has the wrong number of columns");
      end
      for (int k = 0; k < n_fields; k++) begin
        fields.push_back(v[k]);
      end
      nvec++;
    end
    $fclose(fd);
    if (nvec == 0) begin
      report_failure("the golden vector file holds no vectors");
    end
  endtask

  function automatic logic [63:0] field(input int vec, input int col);
    return fields[vec * n_fields + col];
  endfunction

  // watchdog sized from the vector count
  initial begin
    wait (loaded);
    #((nvec + 20) * 20);
    report_failure("timeout, the test did not finish in time");
  end

  initial begin
    logic [63:0] mask;
    logic [63:0] exp_pc;
    i_rst_n          = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_to_ds_bus   = '0;
    i_es_allowin     = 1'b1;
    i_es_load_sel    = 1'b0;
    i_es_bypass      = '0;
    i_ms_bypass      = '0;
    i_ws_bypass      = '0;
    i_ws_to_rf       = '0;
    nvec             = 0;
    loaded           = 1'b0;
    exp_pc           = '0; // latch is cleared by reset
    load_vectors();
    loaded = 1'b1;
    repeat (10) @(posedge i_clk);
    i_rst_n <= 1'b1;
    for (int n = 0; n < nvec; n++) begin
      @(posedge i_clk);
      i_fs_to_ds_valid <= 1'(field(n, 0));
      i_fs_to_ds_bus   <= {32'(field(n, 1)), field(n, 2)};
      i_es_allowin     <= 1'(field(n, 3));
      i_es_load_sel    <= 1'(field(n, 4));
      i_es_bypass      <= {5'(field(n, 5)), field(n, 6)};
      i_ms_bypass      <= {5'(field(n, 7)), field(n, 8)};
      i_ws_bypass      <= {5'(field(n, 9)), field(n, 10)};
      i_ws_to_rf       <= {1'(field(n, 11)), 5'(field(n, 12)), field(n, 13)};
      #18; // just before the next edge
      mask = field(n, 14);
      if (mask[0]) check_value("o_ds_allowin", 64'(o_ds_allowin), field(n, 15));
      if (mask[1]) check_value("o_ds_to_es_valid", 64'(o_ds_to_es_valid), field(n, 16));
      if (mask[2]) check_value("o_ds_to_es_bus.rd", 64'(o_ds_to_es_bus.rd), field(n, 17));
      if (mask[3]) check_value("o_ds_to_es_bus.imm", o_ds_to_es_bus.imm, field(n, 18));
      if (mask[4]) check_value("o_ds_to_es_bus.ctrl.alu_op",
                               64'(o_ds_to_es_bus.ctrl.alu_op), field(n, 19));
      if (mask[5]) check_value("o_ds_to_es_bus.ctrl enables",
                               64'({o_ds_to_es_bus.ctrl.invalid_sel, o_ds_to_es_bus.ctrl.gpr_wen,
                                    o_ds_to_es_bus.ctrl.mem_ren, o_ds_to_es_bus.ctrl.mem_wen}),
                               field(n, 20));
      if (mask[6]) check_value("o_ds_to_es_bus.rs1_data", o_ds_to_es_bus.rs1_data, field(n, 21));
      if (mask[7]) check_value("o_ds_to_es_bus.rs2_data", o_ds_to_es_bus.rs2_data, field(n, 22));
      if (mask[8]) check_value("o_br_bus.stall", 64'(o_br_bus.stall), field(n, 23));
      if (mask[9]) check_value("o_br_bus.taken", 64'(o_br_bus.taken), field(n, 24));
      if (mask[10]) check_value("o_br_bus.target", o_br_bus.target, field(n, 25));
      check_value("o_ds_to_es_bus.pc", o_ds_to_es_bus.pc, exp_pc);
      if (i_dut.u_ctrl.u_asserts.fail_count != 0) begin
        report_failure("a handshake assertion on the decode stage control failed");
      end
      // fetch handshake on the coming edge loads a new pc
      if ((field(n, 0) != '0) && (field(n, 15) != '0)) begin
        exp_pc = field(n, 2);
      end
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: testbench/id_golden.txt
# fs_valid inst pc es_allowin es_load es_rd es_res ms_rd ms_res ws_rd ws_res wen waddr wdata
# mask allowin valid rd imm alu_op {inv,wen,ren,wen} rs1 rs2 stall taken target (all hex)
0 0 0 1 0 0 0 0 0 0 0 1 2 64 303 1 0 0 0 0 0 0 0 0 0 0
0 0 0 1 0 0 0 0 0 0 0 1 4 50 303 1 0 0 0 0 0 0 0 0 0 0
0 0 0 1 0 0 0 0 0 0 0 1 5 8 303 1 0 0 0 0 0 0 0 0 0 0
0 0 0 1 0 0 0 0 0 0 0 1 9 fffffffffffffffd 303 1 0 0 0 0 0 0 0 0 0 0
0 0 0 1 0 0 0 0 0 0 0 1 a 7 303 1 0 0 0 0 0 0 0 0 0 0
0 0 0 1 0 0 0 0 0 0 0 1 b 20 303 1 0 0 0 0 0 0 0 0 0 0
1 ffb10093 1000 1 0 0 0 0 0 0 0 1 0 99 303 1 0 0 0 0 0 0 0 0 0 0
1 405201b3 1004 1 0 0 0 0 0 0 0 0 0 0 3ff 1 1 1 fffffffffffffffb 0 4 64 0 0 0 0
1 fe63ae23 1008 1 0 0 0 0 0 0 0 0 0 0 3ff 1 1 3 0 1 4 50 8 0 0 0
1 12345437 100c 1 0 0 0 0 0 0 0 0 0 0 3ff 1 1 1c fffffffffffffffc 0 1 0 0 0 0 0
1 7f 1010 1 0 0 0 0 0 0 0 0 0 0 3ff 1 1 8 12345000 a 4 0 0 0 0 0
1 002006b3 1014 1 0 0 0 0 0 0 0 0 0 0 3ff 1 1 0 0 0 8 0 0 0 0 0
1 00510733 1018 1 0 0 dead 0 0 0 0 0 0 0 3ff 1 1 d 0 0 4 0 64 0 0 0
1 00510733 101c 1 0 2 111 2 222 2 333 0 0 0 3ff 1 1 e 0 0 4 111 8 0 0 0
1 405201b3 1020 1 0 0 111 2 222 2 333 0 0 0 3ff 1 1 e 0 0 4 222 8 0 0 0
1 fe63ae23 1024 1 1 5 77 0 0 0 0 0 0 0 3ff 0 0 3 0 1 4 50 77 0 0 0
1 fe63ae23 1024 1 1 5 77 0 0 0 0 0 0 0 3ff 0 0 3 0 1 4 50 77 0 0 0
1 fea4cce3 100 1 0 0 0 0 0 0 0 0 0 0 3ff 1 1 3 0 1 4 50 8 0 0 0
1 fea4cce3 100 1 0 0 0 0 0 0 0 0 0 0 7fb 1 1 0 fffffffffffffff8 0 0 fffffffffffffffd 7 0 1 f8
1 00558067 200 1 1 9 0 0 0 0 0 0 0 0 7fb 0 0 0 fffffffffffffff8 0 0 0 7 1 1 f8
1 00558067 200 1 0 0 0 0 0 0 0 0 0 0 7fb 1 1 0 fffffffffffffff8 0 0 fffffffffffffffd 7 0 1 f8
1 010000ef 300 1 0 0 0 0 0 0 0 0 0 0 7ff 1 1 0 5 0 4 20 8 0 1 24
1 12345437 400 0 0 0 0 0 0 0 0 0 0 0 7ff 0 1 1 10 0 4 0 0 0 1 310
1 12345437 400 0 0 0 0 0 0 0 0 0 0 0 7ff 0 1 1 10 0 4 0 0 0 1 310
1 12345437 400 0 0 0 0 0 0 0 0 0 0 0 7ff 0 1 1 10 0 4 0 0 0 1 310
1 12345437 400 1 0 0 0 0 0 0 0 0 0 0 7ff 1 1 1 10 0 4 0 0 0 1 310
0 0 0 1 0 0 0 0 0 0 0 0 0 0 3ff 1 1 8 12345000 a 4 0 0 0 0 0
0 0 0 1 0 0 0 0 0 0 0 0 0 0 303 1 0 0 0 0 0 0 0 0 0 0

// File: sim.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/id_stage_ctrl.sv
logic/inst_decoder.sv
logic/gpr_file.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/id_stage.sv
testbench/id_stage_asserts.sv
testbench/tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_id_stage
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
